/* src/udp_rx_pkg.sv */
// UDP receive shared definitions

package udp_rx_pkg;

    // stream and header word types
    typedef logic [7:0]  byte_t;
    typedef logic [15:0] field_t;
    typedef logic [31:0] ip_addr_t;

    // byte position inside the IP payload, header included
    typedef logic [15:0] frame_ptr_t;

    // UDP header is four big-endian 16-bit fields
    localparam int UDP_HDR_BYTES = 8;
    localparam int UDP_FIELD_COUNT = 4;

    // field order: source port, destination port, length, checksum
    localparam int FIELD_LENGTH = 2;

    // receive control FSM
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_HEADER,
        ST_READ_PAYLOAD,
        // length reached, drop bytes until the frame ends
        ST_READ_PAYLOAD_LAST
    } rx_state_t;

endpackage

/* src/udp_rx_ctrl.sv */
// UDP receive frame control

module udp_rx_ctrl
    import udp_rx_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       s_ip_hdr_valid,
    input  logic       s_tvalid,
    input  logic       s_tlast,
    input  logic       s_tuser,
    input  byte_t      s_tdata,
    input  logic       hdr_pending,
    input  logic       ready_early,
    input  field_t     udp_length,
    output logic       s_ip_hdr_ready,
    output logic       s_tready,
    output logic       hdr_store,
    output logic       field_byte_we,
    output logic       hdr_done,
    output frame_ptr_t frame_ptr,
    output byte_t      int_tdata,
    output logic       int_tvalid,
    output logic       int_tlast,
    output logic       int_tuser,
    output logic       busy,
    output logic       error_header_early_termination,
    output logic       error_payload_early_termination
);

    localparam frame_ptr_t LAST_HDR_POS = frame_ptr_t'(UDP_HDR_BYTES - 1);

    rx_state_t  state_reg;
    rx_state_t  state_next;
    frame_ptr_t ptr_next;
    logic       hdr_ready_next;
    logic       tready_next;
    logic       err_hdr_next;
    logic       err_pay_next;
    logic       store_last;
    logic       in_xfer;

    // byte held back until the frame's tlast shows up
    byte_t      last_byte_reg;

    assign in_xfer = s_tready && s_tvalid;

    always_comb begin
        state_next = state_reg;
        ptr_next = frame_ptr;
        hdr_ready_next = 1'b0;
        tready_next = 1'b0;
        hdr_store = 1'b0;
        field_byte_we = 1'b0;
        hdr_done = 1'b0;
        store_last = 1'b0;
        err_hdr_next = 1'b0;
        err_pay_next = 1'b0;

        int_tdata = s_tdata;
        int_tvalid = 1'b0;
        int_tlast = 1'b0;
        int_tuser = 1'b0;

        case (state_reg)
            ST_IDLE: begin
                ptr_next = '0;
                // hold off the next frame while a header waits downstream
                hdr_ready_next = !hdr_pending;
                if (s_ip_hdr_ready && s_ip_hdr_valid) begin
                    hdr_ready_next = 1'b0;
                    tready_next = 1'b1;
                    hdr_store = 1'b1;
                    state_next = ST_READ_HEADER;
                end
            end
            ST_READ_HEADER: begin
                tready_next = 1'b1;
                if (in_xfer) begin
                    ptr_next = frame_ptr + 1'b1;
                    field_byte_we = 1'b1;
                    if (s_tlast) begin
                        // frame ended inside the UDP header
                        err_hdr_next = 1'b1;
                        hdr_ready_next = !hdr_pending;
                        tready_next = 1'b0;
                        state_next = ST_IDLE;
                    end else if (frame_ptr == LAST_HDR_POS) begin
                        hdr_done = 1'b1;
                        tready_next = ready_early;
                        state_next = ST_READ_PAYLOAD;
                    end
                end
            end
            ST_READ_PAYLOAD: begin
                tready_next = ready_early;
                int_tvalid = s_tvalid;
                int_tlast = s_tlast;
                int_tuser = s_tuser;
                if (in_xfer) begin
                    ptr_next = frame_ptr + 1'b1;
                    if (s_tlast) begin
                        // short frame, flag the last byte
                        if (ptr_next != udp_length) begin
                            int_tuser = 1'b1;
                            err_pay_next = 1'b1;
                        end
                        hdr_ready_next = !hdr_pending;
                        tready_next = 1'b0;
                        state_next = ST_IDLE;
                    end else if (ptr_next == udp_length) begin
                        store_last = 1'b1;
                        int_tvalid = 1'b0;
                        state_next = ST_READ_PAYLOAD_LAST;
                    end
                end
            end
            ST_READ_PAYLOAD_LAST: begin
                tready_next = ready_early;
                int_tdata = last_byte_reg;
                int_tvalid = s_tvalid && s_tlast;
                int_tlast = s_tlast;
                int_tuser = s_tuser;
                if (in_xfer && s_tlast) begin
                    hdr_ready_next = !hdr_pending;
                    tready_next = 1'b0;
                    state_next = ST_IDLE;
                end
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_reg <= ST_IDLE;
            frame_ptr <= '0;
            s_ip_hdr_ready <= 1'b0;
            s_tready <= 1'b0;
            busy <= 1'b0;
            error_header_early_termination <= 1'b0;
            error_payload_early_termination <= 1'b0;
        end else begin
            state_reg <= state_next;
            frame_ptr <= ptr_next;
            s_ip_hdr_ready <= hdr_ready_next;
            s_tready <= tready_next;
            busy <= state_next != ST_IDLE;
            error_header_early_termination <= err_hdr_next;
            error_payload_early_termination <= err_pay_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_last) begin
            last_byte_reg <= s_tdata;
        end
    end

    // a new header is only taken once the previous one has left
    hdr_store_not_pending: assert property (
        @(posedge clk) disable iff (rst) hdr_store |-> !hdr_pending
    );

endmodule

/* src/udp_field_capture.sv */
// UDP header field capture

module udp_field_capture
    import udp_rx_pkg::*;
#(
    parameter int FIELD_INDEX = 0
) (
    input  logic       clk,
    input  logic       field_byte_we,
    input  frame_ptr_t frame_ptr,
    input  byte_t      s_tdata,
    output field_t     field
);

    // big-endian, high byte first
    localparam frame_ptr_t HI_POS = frame_ptr_t'(2 * FIELD_INDEX);
    localparam frame_ptr_t LO_POS = frame_ptr_t'(2 * FIELD_INDEX + 1);

    logic hi_we;
    logic lo_we;

    assign hi_we = field_byte_we && (frame_ptr == HI_POS);
    assign lo_we = field_byte_we && (frame_ptr == LO_POS);

    always_ff @(posedge clk) begin
        if (hi_we) begin
            field[15:8] <= s_tdata;
        end
        if (lo_we) begin
            field[7:0] <= s_tdata;
        end
    end

endmodule

/* src/udp_hdr_out.sv */
// UDP output header channel

module udp_hdr_out
    import udp_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     hdr_store,
    input  logic     hdr_done,
    input  logic     m_udp_hdr_ready,
    input  ip_addr_t ip_source_ip,
    input  ip_addr_t ip_dest_ip,
    output logic     m_udp_hdr_valid,
    output logic     hdr_pending,
    output ip_addr_t m_ip_source_ip,
    output ip_addr_t m_ip_dest_ip
);

    logic valid_next;

    // controller sees our valid so it can stall the next frame
    assign hdr_pending = m_udp_hdr_valid;

    always_comb begin
        valid_next = m_udp_hdr_valid && !m_udp_hdr_ready;
        if (hdr_done) begin
            valid_next = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            m_udp_hdr_valid <= 1'b0;
        end else begin
            m_udp_hdr_valid <= valid_next;
        end
    end

    // addresses taken with the input header
    always_ff @(posedge clk) begin
        if (hdr_store) begin
            m_ip_source_ip <= ip_source_ip;
            m_ip_dest_ip <= ip_dest_ip;
        end
    end

    // a waiting header keeps its addresses until it is taken
    hdr_addr_held: assert property (
        @(posedge clk) disable iff (rst)
        m_udp_hdr_valid && !m_udp_hdr_ready |=>
            $stable(m_ip_source_ip) && $stable(m_ip_dest_ip)
    );

endmodule

/* src/udp_payload_skid.sv */
// UDP payload output skid buffer

module udp_payload_skid
    import udp_rx_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  byte_t int_tdata,
    input  logic  int_tvalid,
    input  logic  int_tlast,
    input  logic  int_tuser,
    input  logic  m_tready,
    output logic  ready_early,
    output byte_t m_tdata,
    output logic  m_tvalid,
    output logic  m_tlast,
    output logic  m_tuser
);

    logic  ready_reg;
    logic  m_tvalid_next;

    byte_t temp_tdata;
    logic  temp_tvalid;
    logic  temp_tvalid_next;
    logic  temp_tlast;
    logic  temp_tuser;

    logic  in_to_out;
    logic  in_to_temp;
    logic  temp_to_out;

    // ready next cycle unless the temp register could fill now
    assign ready_early = m_tready || (!temp_tvalid && (!m_tvalid || !int_tvalid));

    always_comb begin
        m_tvalid_next = m_tvalid;
        temp_tvalid_next = temp_tvalid;
        in_to_out = 1'b0;
        in_to_temp = 1'b0;
        temp_to_out = 1'b0;

        if (ready_reg) begin
            if (m_tready || !m_tvalid) begin
                m_tvalid_next = int_tvalid;
                in_to_out = 1'b1;
            end else begin
                // output stalled, park the byte
                temp_tvalid_next = int_tvalid;
                in_to_temp = 1'b1;
            end
        end else if (m_tready) begin
            m_tvalid_next = temp_tvalid;
            temp_tvalid_next = 1'b0;
            temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ready_reg <= 1'b0;
            m_tvalid <= 1'b0;
            temp_tvalid <= 1'b0;
        end else begin
            ready_reg <= ready_early;
            m_tvalid <= m_tvalid_next;
            temp_tvalid <= temp_tvalid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (in_to_out) begin
            m_tdata <= int_tdata;
            m_tlast <= int_tlast;
            m_tuser <= int_tuser;
        end else if (temp_to_out) begin
            m_tdata <= temp_tdata;
            m_tlast <= temp_tlast;
            m_tuser <= temp_tuser;
        end
        if (in_to_temp) begin
            temp_tdata <= int_tdata;
            temp_tlast <= int_tlast;
            temp_tuser <= int_tuser;
        end
    end

    // the early ready must keep writes away from a full temp register
    temp_no_overrun: assert property (
        @(posedge clk) disable iff (rst) ready_reg |-> !temp_tvalid
    );

endmodule

/* src/udp_ip_rx.sv */
// UDP receive stage top

module udp_ip_rx
    import udp_rx_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // IP header and payload in
    input  logic     s_ip_hdr_valid,
    output logic     s_ip_hdr_ready,
    input  ip_addr_t ip_source_ip,
    input  ip_addr_t ip_dest_ip,
    input  byte_t    s_tdata,
    input  logic     s_tvalid,
    output logic     s_tready,
    input  logic     s_tlast,
    input  logic     s_tuser,

    // UDP header and payload out
    output logic     m_udp_hdr_valid,
    input  logic     m_udp_hdr_ready,
    output field_t   m_udp_source_port,
    output field_t   m_udp_dest_port,
    output field_t   m_udp_length,
    output field_t   m_udp_checksum,
    output ip_addr_t m_ip_source_ip,
    output ip_addr_t m_ip_dest_ip,
    output byte_t    m_tdata,
    output logic     m_tvalid,
    input  logic     m_tready,
    output logic     m_tlast,
    output logic     m_tuser,

    output logic     busy,
    output logic     error_header_early_termination,
    output logic     error_payload_early_termination
);

    logic       hdr_store;
    logic       field_byte_we;
    logic       hdr_done;
    logic       hdr_pending;
    logic       ready_early;
    frame_ptr_t frame_ptr;
    byte_t      int_tdata;
    logic       int_tvalid;
    logic       int_tlast;
    logic       int_tuser;
    field_t     fields [UDP_FIELD_COUNT];

    udp_rx_ctrl u_ctrl (
        .clk                             (clk),
        .rst                             (rst),
        .s_ip_hdr_valid                  (s_ip_hdr_valid),
        .s_tvalid                        (s_tvalid),
        .s_tlast                         (s_tlast),
        .s_tuser                         (s_tuser),
        .s_tdata                         (s_tdata),
        .hdr_pending                     (hdr_pending),
        .ready_early                     (ready_early),
        .udp_length                      (fields[FIELD_LENGTH]),
        .s_ip_hdr_ready                  (s_ip_hdr_ready),
        .s_tready                        (s_tready),
        .hdr_store                       (hdr_store),
        .field_byte_we                   (field_byte_we),
        .hdr_done                        (hdr_done),
        .frame_ptr                       (frame_ptr),
        .int_tdata                       (int_tdata),
        .int_tvalid                      (int_tvalid),
        .int_tlast                       (int_tlast),
        .int_tuser                       (int_tuser),
        .busy                            (busy),
        .error_header_early_termination  (error_header_early_termination),
        .error_payload_early_termination (error_payload_early_termination)
    );

    // one capture per header field
    for (genvar i = 0; i < UDP_FIELD_COUNT; i++) begin : g_field
        udp_field_capture #(
            .FIELD_INDEX (i)
        ) u_capture (
            .clk           (clk),
            .field_byte_we (field_byte_we),
            .frame_ptr     (frame_ptr),
            .s_tdata       (s_tdata),
            .field         (fields[i])
        );
    end

    assign m_udp_source_port = fields[0];
    assign m_udp_dest_port = fields[1];
    assign m_udp_length = fields[2];
    assign m_udp_checksum = fields[3];

    udp_hdr_out u_hdr_out (
        .clk             (clk),
        .rst             (rst),
        .hdr_store       (hdr_store),
        .hdr_done        (hdr_done),
        .m_udp_hdr_ready (m_udp_hdr_ready),
        .ip_source_ip    (ip_source_ip),
        .ip_dest_ip      (ip_dest_ip),
        .m_udp_hdr_valid (m_udp_hdr_valid),
        .hdr_pending     (hdr_pending),
        .m_ip_source_ip  (m_ip_source_ip),
        .m_ip_dest_ip    (m_ip_dest_ip)
    );

    udp_payload_skid u_skid (
        .clk         (clk),
        .rst         (rst),
        .int_tdata   (int_tdata),
        .int_tvalid  (int_tvalid),
        .int_tlast   (int_tlast),
        .int_tuser   (int_tuser),
        .m_tready    (m_tready),
        .ready_early (ready_early),
        .m_tdata     (m_tdata),
        .m_tvalid    (m_tvalid),
        .m_tlast     (m_tlast),
        .m_tuser     (m_tuser)
    );

endmodule

/* verif/udp_rx_model.svh */
// UDP receive reference model

// frame kinds
localparam int KIND_EXACT = 0;
localparam int KIND_LONG = 1;
localparam int KIND_SHORT = 2;
localparam int KIND_HDR_SHORT = 3;

// bytes of the frame being sent, UDP header first
byte_t frame_bytes[$];

// expected header: ports, length, checksum, source ip, dest ip
logic [127:0] exp_hdr_q[$];

// expected payload beat: {tuser, tlast, tdata}
logic [9:0] exp_pay_q[$];

int exp_hdr_errors = 0;
int exp_pay_errors = 0;

function automatic void build_frame(input int kind, input ip_addr_t src_ip,
                                    input ip_addr_t dst_ip);
    field_t src_port;
    field_t dst_port;
    field_t udp_len;
    field_t csum;
    int frame_len;
    int kept;
    int i;

    src_port = field_t'($urandom);
    dst_port = field_t'($urandom);
    csum = field_t'($urandom);
    // UDP length covers the header plus at least two payload bytes
    udp_len = field_t'($urandom_range(10, 40));
    case (kind)
        KIND_EXACT: frame_len = udp_len;
        KIND_LONG: frame_len = udp_len + $urandom_range(1, 6);
        KIND_SHORT: frame_len = $urandom_range(9, udp_len - 1);
        default: frame_len = $urandom_range(1, 8);
    endcase

    frame_bytes.delete();
    frame_bytes.push_back(src_port[15:8]);
    frame_bytes.push_back(src_port[7:0]);
    frame_bytes.push_back(dst_port[15:8]);
    frame_bytes.push_back(dst_port[7:0]);
    frame_bytes.push_back(udp_len[15:8]);
    frame_bytes.push_back(udp_len[7:0]);
    frame_bytes.push_back(csum[15:8]);
    frame_bytes.push_back(csum[7:0]);
    for (i = UDP_HDR_BYTES; i < frame_len; i++) begin
        frame_bytes.push_back(byte_t'($urandom));
    end
    // header-short frames stop somewhere inside the 8 header bytes
    while (frame_bytes.size() > frame_len) begin
        void'(frame_bytes.pop_back());
    end

    if (kind == KIND_HDR_SHORT) begin
        exp_hdr_errors++;
        return;
    end

    exp_hdr_q.push_back({src_port, dst_port, udp_len, csum, src_ip, dst_ip});
    kept = (frame_len < udp_len) ? frame_len : udp_len;
    for (i = UDP_HDR_BYTES; i < kept; i++) begin
        exp_pay_q.push_back({(i == kept - 1) && (frame_len < udp_len), i == kept - 1,
                             frame_bytes[i]});
    end
    if (frame_len < udp_len) begin
        exp_pay_errors++;
    end
endfunction

/* verif/tb_udp_ip_rx.sv */
// UDP receive stage testbench

module tb_udp_ip_rx
    import udp_rx_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SEED = 36;
    localparam int NUM_FRAMES = 60;
    localparam int TIMEOUT = 1000;

    logic     clk;
    logic     rst;
    logic     s_ip_hdr_valid;
    logic     s_ip_hdr_ready;
    ip_addr_t ip_source_ip;
    ip_addr_t ip_dest_ip;
    byte_t    s_tdata;
    logic     s_tvalid;
    logic     s_tready;
    logic     s_tlast;
    logic     s_tuser;
    logic     m_udp_hdr_valid;
    logic     m_udp_hdr_ready;
    field_t   m_udp_source_port;
    field_t   m_udp_dest_port;
    field_t   m_udp_length;
    field_t   m_udp_checksum;
    ip_addr_t m_ip_source_ip;
    ip_addr_t m_ip_dest_ip;
    byte_t    m_tdata;
    logic     m_tvalid;
    logic     m_tready;
    logic     m_tlast;
    logic     m_tuser;
    logic     busy;
    logic     error_header_early_termination;
    logic     error_payload_early_termination;

    logic stall_en = 1'b0;
    logic timed_out = 1'b0;
    int   errors = 0;
    int   hdr_checked = 0;
    int   pay_checked = 0;
    int   seen_hdr_errors = 0;
    int   seen_pay_errors = 0;

    `include "udp_rx_model.svh"

    udp_ip_rx u_udp_ip_rx (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL %s expected %0h actual %0h", name, expected, actual);
        end
    endtask

    task automatic note_error(input string reason);
        errors++;
        $display("ERROR %s", reason);
    endtask

    task automatic print_counts();
        $display("errors %0d, headers checked %0d, payload bytes checked %0d",
                 errors, hdr_checked, pay_checked);
    endtask

    task automatic report_timeout(input string reason);
        note_error(reason);
        timed_out = 1'b1;
    endtask

    task automatic send_ip_header(input ip_addr_t src_ip, input ip_addr_t dst_ip);
        int wait_cycles;
        s_ip_hdr_valid <= 1'b1;
        ip_source_ip <= src_ip;
        ip_dest_ip <= dst_ip;
        wait_cycles = 0;
        do begin
            @(posedge clk);
            wait_cycles++;
        end while (!s_ip_hdr_ready && wait_cycles < TIMEOUT);
        if (!s_ip_hdr_ready) begin
            report_timeout("input header was never accepted");
        end
        s_ip_hdr_valid <= 1'b0;
    endtask

    task automatic send_frame_bytes();
        int gap;
        int wait_cycles;
        int i;
        for (i = 0; i < frame_bytes.size(); i++) begin
            gap = ($urandom_range(0, 3) == 0) ? $urandom_range(1, 3) : 0;
            if (gap > 0) begin
                s_tvalid <= 1'b0;
                s_tlast <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            s_tdata <= frame_bytes[i];
            s_tlast <= (i == frame_bytes.size() - 1);
            s_tvalid <= 1'b1;
            wait_cycles = 0;
            do begin
                @(posedge clk);
                wait_cycles++;
            end while (!s_tready && wait_cycles < TIMEOUT);
            if (!s_tready) begin
                report_timeout("payload byte was never accepted");
                break;
            end
        end
        s_tvalid <= 1'b0;
        s_tlast <= 1'b0;
    endtask

    task automatic check_header();
        logic [127:0] exp;
        if (exp_hdr_q.size() == 0) begin
            note_error("a UDP header came out that no frame should produce");
        end else begin
            exp = exp_hdr_q.pop_front();
            check_value("header source port", exp[127:112], m_udp_source_port);
            check_value("header dest port", exp[111:96], m_udp_dest_port);
            check_value("header length", exp[95:80], m_udp_length);
            check_value("header checksum", exp[79:64], m_udp_checksum);
            check_value("header source ip", exp[63:32], m_ip_source_ip);
            check_value("header dest ip", exp[31:0], m_ip_dest_ip);
            hdr_checked++;
        end
    endtask

    task automatic check_payload();
        logic [9:0] exp;
        if (exp_pay_q.size() == 0) begin
            note_error("a payload byte came out that no frame should produce");
        end else begin
            exp = exp_pay_q.pop_front();
            check_value($sformatf("payload byte %0d tdata", pay_checked), exp[7:0], m_tdata);
            check_value($sformatf("payload byte %0d tlast", pay_checked), exp[8], m_tlast);
            check_value($sformatf("payload byte %0d tuser", pay_checked), exp[9], m_tuser);
            pay_checked++;
        end
    endtask

    // output readies stall at random in the later frames
    always @(posedge clk) begin
        if (stall_en) begin
            m_tready <= ($urandom_range(0, 3) != 0);
            m_udp_hdr_ready <= ($urandom_range(0, 3) == 0);
        end else begin
            m_tready <= 1'b1;
            m_udp_hdr_ready <= 1'b1;
        end
    end

    // scoreboard
    always @(posedge clk) begin
        if (!rst) begin
            if (m_udp_hdr_valid && m_udp_hdr_ready) begin
                check_header();
            end
            if (m_tvalid && m_tready) begin
                check_payload();
            end
            if (error_header_early_termination) begin
                seen_hdr_errors++;
            end
            if (error_payload_early_termination) begin
                seen_pay_errors++;
            end
        end
    end

    initial begin
        int kind;
        int n;
        int wait_cycles;
        ip_addr_t src_ip;
        ip_addr_t dst_ip;

        void'($urandom(SEED));
        rst <= 1'b1;
        s_ip_hdr_valid <= 1'b0;
        ip_source_ip <= '0;
        ip_dest_ip <= '0;
        s_tdata <= '0;
        s_tvalid <= 1'b0;
        s_tlast <= 1'b0;
        s_tuser <= 1'b0;
        m_tready <= 1'b0;
        m_udp_hdr_ready <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        check_value("reset s_ip_hdr_ready", 0, s_ip_hdr_ready);
        check_value("reset s_tready", 0, s_tready);
        check_value("reset m_udp_hdr_valid", 0, m_udp_hdr_valid);
        check_value("reset m_tvalid", 0, m_tvalid);
        check_value("reset busy", 0, busy);
        check_value("reset header error", 0, error_header_early_termination);
        check_value("reset payload error", 0, error_payload_early_termination);

        for (n = 0; n < NUM_FRAMES && !timed_out; n++) begin
            // first third runs without output stalls
            stall_en <= (n >= NUM_FRAMES / 3);
            kind = (n < 4) ? n : $urandom_range(KIND_EXACT, KIND_HDR_SHORT);
            src_ip = ip_addr_t'($urandom);
            dst_ip = ip_addr_t'($urandom);
            build_frame(kind, src_ip, dst_ip);
            send_ip_header(src_ip, dst_ip);
            if (!timed_out) begin
                send_frame_bytes();
            end
        end

        if (!timed_out) begin
            wait_cycles = 0;
            while ((exp_hdr_q.size() != 0 || exp_pay_q.size() != 0 || busy)
                   && wait_cycles < TIMEOUT) begin
                @(posedge clk);
                wait_cycles++;
            end
            if (wait_cycles >= TIMEOUT) begin
                report_timeout("outputs did not drain after the last frame");
            end
            // let the last error pulse reach the scoreboard
            repeat (3) @(posedge clk);

            check_value("header error pulses", exp_hdr_errors, seen_hdr_errors);
            check_value("payload error pulses", exp_pay_errors, seen_pay_errors);
            check_value("m_udp_hdr_valid at end", 0, m_udp_hdr_valid);
            check_value("m_tvalid at end", 0, m_tvalid);
        end

        print_counts();
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* project.f */
+incdir+verif
src/udp_rx_pkg.sv
src/udp_rx_ctrl.sv
src/udp_field_capture.sv
src/udp_hdr_out.sv
src/udp_payload_skid.sv
src/udp_ip_rx.sv
verif/tb_udp_ip_rx.sv
